//--- echoPortal.f
+incdir+hdl
hdl/portalPkg.sv
hdl/portalBurstCounter.sv
hdl/portalSequencer.sv
hdl/portalCtrlRegs.sv
hdl/echoQueue.sv
hdl/echoPortal.sv
tests/echoPortalTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module echoPortalTb -f echoPortal.f -o echoPortalSim
./obj_dir/echoPortalSim

//--- tests/echoPortalTb.sv
`timescale 1ns/1ns
`include "portal_params.svh"

module echoPortalTb;
  logic CLK;
  logic RST_N;
  logic [`PORTAL_REQ_W-1:0] rdReq;
  logic [`PORTAL_REQ_W-1:0] wrReq;
  logic [`PORTAL_DATA_W-1:0] wrData;
  logic [`PORTAL_RDDATA_W-1:0] rdData;
  logic [`PORTAL_TAG_W-1:0] wrDone;
  logic intr;
  logic [4:0] enables;                       // rdReq, rdData, wrReq, wrData, wrDone
  wire [4:0] readies;

  logic [31:0] modelQ[$];
  logic [`PORTAL_RDDATA_W-1:0] expectQ[$];
  logic modelEnable;
  logic [4:0] wrCursor;                      // Address of the write counter
  logic [5:0] tag;
  logic [5:0] pendingTag;
  integer seed;

  echoPortal DUT (
    .CLK(CLK), .RST_N(RST_N),
    .rdReq(rdReq), .enRdReq(enables[0]), .rdyRdReq(readies[0]),
    .rdData(rdData), .enRdData(enables[1]), .rdyRdData(readies[1]),
    .wrReq(wrReq), .enWrReq(enables[2]), .rdyWrReq(readies[2]),
    .wrData(wrData), .enWrData(enables[3]), .rdyWrData(readies[3]),
    .wrDone(wrDone), .enWrDone(enables[4]), .rdyWrDone(readies[4]),
    .intr(intr)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  task automatic stopRun(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic checkValue(input string name, input logic [63:0] actual,
                            input logic [63:0] expected);
    if (actual !== expected) begin
      stopRun($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  function automatic logic [31:0] expectedRead(input logic space, input logic [4:0] address,
                                               input logic [31:0] modelQueue[$],
                                               input logic enable);
    logic pending;
    pending = modelQueue.size() != 0;
    if (!space) begin
      if (address == 5'd0) return modelQueue[0];
      if (address == 5'd4) return {31'b0, pending};
      return 32'h0;
    end
    case (address)
      5'd0: return {31'b0, pending};
      5'd4: return {31'b0, enable};
      5'd8: return 32'd1;
      5'd12: return {31'b0, pending};
      5'd16: return 32'd5;
      5'd20: return 32'd2;
      5'd24, 5'd28: return 32'h0;
      default: return 32'h005A05A0;
    endcase
  endfunction

  task automatic transfer(input int port, input string what);
    int waited;
    waited = 0;
    enables[port] = 1'b1;
    while (!readies[port]) begin
      @(posedge CLK);
      #1;
      waited++;
      if (waited > 200) stopRun($sformatf("Timed out waiting for the %s handshake", what));
    end
    @(posedge CLK);
    #1;
    enables[port] = 1'b0;
  endtask

  task automatic checkIntr();
    @(posedge CLK);
    #1;
    checkValue("intr", 64'(intr), 64'(modelEnable && modelQ.size() != 0));
  endtask

  task automatic readBurst(input logic space, input logic [4:0] addr, input int len);
    logic [4:0] beatAddr;
    logic [31:0] value;
    tag = tag + 6'd1;
    beatAddr = addr;
    for (int i = 0; i < len; i++) begin
      value = expectedRead(space, beatAddr, modelQ, modelEnable);
      if (!space && beatAddr == 5'd0) begin
        void'(modelQ.pop_front());
      end
      expectQ.push_back({value, tag, i == len - 1});
      beatAddr = beatAddr + 5'd4;            // Wraps mod 32
    end
    rdReq = {tag, 8'(len), addr, space};
    transfer(0, "read request");
    for (int i = 0; i < len; i++) begin
      repeat ($unsigned($random(seed)) % 4) begin   // Host stalls the beat
        @(posedge CLK);
        #1;
      end
      transfer(1, "read data");
    end
    checkValue("rdyRdData", 64'(readies[1]), 64'(0));  // No beat beyond the burst
    checkIntr();
  endtask

  task automatic startWrite(input logic space, input logic [4:0] addr, input int len);
    tag = tag + 6'd1;
    pendingTag = tag;
    wrReq = {tag, 8'(len), addr, space};
    transfer(2, "write request");
    wrCursor = addr;
  endtask

  task automatic sendBeat(input logic space, input logic [31:0] value);
    wrData = value;
    transfer(3, "write data");
    if (space && wrCursor == 5'd4) modelEnable = value[0];
    if (!space && wrCursor == 5'd0) modelQ.push_back(value);
    wrCursor = wrCursor + 5'd4;
  endtask

  task automatic takeDone();
    transfer(4, "write done");
    checkValue("wrDone", 64'(wrDone), 64'(pendingTag));
    checkIntr();
  endtask

  // Enable word with random reserved bits
  task automatic writeEnable(input logic enable);
    logic [31:0] value;
    value = $random(seed);
    value[0] = enable;
    startWrite(1'b1, 5'd4, 1);
    sendBeat(1'b1, value);
    takeDone();
  endtask

  always @(negedge CLK) begin : compareRead
    logic [`PORTAL_RDDATA_W-1:0] expected;
    if (RST_N && enables[1] && readies[1]) begin
      expected = expectQ.pop_front();
      checkValue("rdData", 64'(rdData), 64'(expected));
    end
  end

  initial begin
    seed = 29;
    RST_N = 1'b0;
    enables = '0;
    rdReq = '0;
    wrReq = '0;
    wrData = '0;
    modelEnable = 1'b0;
    tag = '0;
    pendingTag = '0;
    wrCursor = '0;
    repeat (2) @(posedge CLK);
    #1;
    RST_N = 1'b1;

    readBurst(1'b1, 5'd0, 8);
    readBurst(1'b1, 5'd2, 2);                // Unaligned offsets hit the magic word

    startWrite(1'b1, 5'd4, 1);
    sendBeat(1'b1, 32'h1);
    takeDone();
    readBurst(1'b1, 5'd4, 1);

    repeat (8) begin
      startWrite(1'b0, 5'd0, 1);
      sendBeat(1'b0, $random(seed));
      takeDone();
    end
    readBurst(1'b0, 5'd4, 1);
    readBurst(1'b1, 5'd0, 8);
    writeEnable(1'b0);
    readBurst(1'b1, 5'd0, 1);
    readBurst(1'b1, 5'd12, 1);
    writeEnable(1'b1);
    readBurst(1'b1, 5'd0, 1);
    readBurst(1'b1, 5'd12, 1);

    // Ninth value waits for room in the queue
    startWrite(1'b0, 5'd0, 1);
    repeat (4) begin
      @(posedge CLK);
      #1;
      checkValue("rdyWrData", 64'(readies[3]), 64'(0));
    end
    readBurst(1'b0, 5'd28, 3);               // Wraps past 28 and pops once
    sendBeat(1'b0, $random(seed));
    takeDone();

    readBurst(1'b1, 5'd28, 2);               // Wraps to the status register
    while (modelQ.size() != 0) begin
      readBurst(1'b0, 5'd0, 1);
    end
    readBurst(1'b0, 5'd4, 1);
    readBurst(1'b1, 5'd0, 2);
    readBurst(1'b1, 5'd12, 1);

    $display("All tests passed!");
    $finish;
  end

endmodule

//--- hdl/echoPortal.sv
`timescale 1ns/1ns
`include "portal_params.svh"

module echoPortal import portalPkg::*; (
  input  logic CLK,
  input  logic RST_N,
  input  logic [`PORTAL_REQ_W-1:0] rdReq,
  input  logic enRdReq,
  output logic rdyRdReq,
  output logic [`PORTAL_RDDATA_W-1:0] rdData,
  input  logic enRdData,
  output logic rdyRdData,
  input  logic [`PORTAL_REQ_W-1:0] wrReq,
  input  logic enWrReq,
  output logic rdyWrReq,
  input  logic [`PORTAL_DATA_W-1:0] wrData,
  input  logic enWrData,
  output logic rdyWrData,
  output logic [`PORTAL_TAG_W-1:0] wrDone,
  input  logic enWrDone,
  output logic rdyWrDone,
  output logic intr
);

  logic rdValid, rdLast, rdSpace, rdStep;
  logic [`PORTAL_ADDR_W-1:0] rdAddr;
  logic [`PORTAL_TAG_W-1:0] rdTag;
  logic wrValid, wrLast, wrSpace, wrStep;
  logic [`PORTAL_ADDR_W-1:0] wrAddr;
  logic [`PORTAL_TAG_W-1:0] wrTag;

  logic [`PORTAL_DATA_W-1:0] ctrlData;
  logic [`PORTAL_DATA_W-1:0] heardValue;
  logic notEmpty, notFull;
  logic sayPush, heardPop, ctrlWrite;
  logic [`PORTAL_ADDR_W-1:0] ctrlAddr;
  portalWordU sayValue;
  portalWordU ctrlWord;

  portalBurstCounter rdCounter (
    .CLK(CLK), .RST_N(RST_N),
    .req(rdReq), .enReq(enRdReq), .rdyReq(rdyRdReq),
    .beatStep(rdStep), .beatValid(rdValid), .beatLast(rdLast),
    .beatSpace(rdSpace), .beatAddr(rdAddr), .beatTag(rdTag)
  );

  portalBurstCounter wrCounter (
    .CLK(CLK), .RST_N(RST_N),
    .req(wrReq), .enReq(enWrReq), .rdyReq(rdyWrReq),
    .beatStep(wrStep), .beatValid(wrValid), .beatLast(wrLast),
    .beatSpace(wrSpace), .beatAddr(wrAddr), .beatTag(wrTag)
  );

  portalSequencer sequencer (
    .CLK(CLK), .RST_N(RST_N),
    .rdValid(rdValid), .rdLast(rdLast), .rdSpace(rdSpace),
    .rdAddr(rdAddr), .rdTag(rdTag), .rdStep(rdStep),
    .wrValid(wrValid), .wrLast(wrLast), .wrSpace(wrSpace),
    .wrAddr(wrAddr), .wrTag(wrTag), .wrStep(wrStep),
    .wrData(wrData), .enWrData(enWrData), .rdyWrData(rdyWrData),
    .rdData(rdData), .enRdData(enRdData), .rdyRdData(rdyRdData),
    .wrDone(wrDone), .enWrDone(enWrDone), .rdyWrDone(rdyWrDone),
    .ctrlData(ctrlData), .heardValue(heardValue),
    .notEmpty(notEmpty), .notFull(notFull),
    .sayPush(sayPush), .sayValue(sayValue), .heardPop(heardPop),
    .ctrlWrite(ctrlWrite), .ctrlAddr(ctrlAddr), .ctrlWord(ctrlWord)
  );

  portalCtrlRegs ctrlRegs (
    .CLK(CLK), .RST_N(RST_N),
    .ctrlWrite(ctrlWrite), .ctrlAddr(ctrlAddr), .ctrlWord(ctrlWord),
    .notEmpty(notEmpty), .ctrlData(ctrlData), .intr(intr)
  );

  echoQueue queue (
    .CLK(CLK), .RST_N(RST_N),
    .sayPush(sayPush), .sayValue(sayValue), .heardPop(heardPop),
    .heardValue(heardValue), .notEmpty(notEmpty), .notFull(notFull)
  );

endmodule

//--- hdl/echoQueue.sv
`timescale 1ns/1ns
`include "portal_params.svh"

module echoQueue import portalPkg::*; (
  input  logic CLK,
  input  logic RST_N,
  input  logic sayPush,
  input  portalWordU sayValue,
  input  logic heardPop,
  output logic [`PORTAL_DATA_W-1:0] heardValue,
  output logic notEmpty,
  output logic notFull
);

  localparam int PtrW = $clog2(`ECHO_DEPTH);
  localparam int CntW = PtrW + 1;

  logic [`PORTAL_DATA_W-1:0] mem [`ECHO_DEPTH];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [CntW-1:0] count;

  assign heardValue = mem[rdPtr];
  assign notEmpty = count != '0;
  assign notFull = count != CntW'(`ECHO_DEPTH);

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (sayPush) wrPtr <= wrPtr + PtrW'(1);
      if (heardPop) rdPtr <= rdPtr + PtrW'(1);
      if (sayPush && !heardPop) begin
        count <= count + CntW'(1);
      end else if (heardPop && !sayPush) begin
        count <= count - CntW'(1);
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (sayPush) mem[wrPtr] <= sayValue.echoValue;
  end

  // Sequencer must hold off the method and the indication
  assert property (@(posedge CLK) disable iff (!RST_N) sayPush |-> notFull);
  assert property (@(posedge CLK) disable iff (!RST_N) heardPop |-> notEmpty);

endmodule

//--- hdl/portalCtrlRegs.sv
`timescale 1ns/1ns
`include "portal_params.svh"

module portalCtrlRegs import portalPkg::*; (
  input  logic CLK,
  input  logic RST_N,
  input  logic ctrlWrite,
  input  logic [`PORTAL_ADDR_W-1:0] ctrlAddr,
  input  portalWordU ctrlWord,
  input  logic notEmpty,
  output logic [`PORTAL_DATA_W-1:0] ctrlData,
  output logic intr
);

  logic intrEnable;
  logic intrStatus;

  assign intrStatus = notEmpty;              // Heard indication pending
  assign intr = intrStatus && intrEnable;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      intrEnable <= 1'b0;
    end else if (ctrlWrite && ctrlAddr == `REG_INTR_ENABLE) begin
      intrEnable <= ctrlWord.ctrlWord.intrEnable;
    end
  end

  always_comb begin
    case (ctrlAddr)
      `REG_INTR_STATUS: begin
        ctrlData = {{(`PORTAL_DATA_W-1){1'b0}}, intrStatus};
      end
      `REG_INTR_ENABLE: begin
        ctrlData = {{(`PORTAL_DATA_W-1){1'b0}}, intrEnable};
      end
      `REG_NUM_INTR: begin
        ctrlData = `NUM_INTR;
      end
      `REG_INTR_CHANNEL: begin
        ctrlData = intrStatus ? `PORTAL_DATA_W'(1) : '0;  // Single channel
      end
      `REG_PORTAL_ID: begin
        ctrlData = `PORTAL_ID;
      end
      `REG_NUM_PORTALS: begin
        ctrlData = `NUM_PORTALS;
      end
      `REG_RESERVED0, `REG_RESERVED1: begin
        ctrlData = '0;
      end
      default: begin
        ctrlData = `PORTAL_MAGIC;
      end
    endcase
  end

endmodule

//--- hdl/portalSequencer.sv
`timescale 1ns/1ns
`include "portal_params.svh"

module portalSequencer import portalPkg::*; (
  input  logic CLK,
  input  logic RST_N,
  input  logic rdValid,
  input  logic rdLast,
  input  logic rdSpace,
  input  logic [`PORTAL_ADDR_W-1:0] rdAddr,
  input  logic [`PORTAL_TAG_W-1:0] rdTag,
  output logic rdStep,
  input  logic wrValid,
  input  logic wrLast,
  input  logic wrSpace,
  input  logic [`PORTAL_ADDR_W-1:0] wrAddr,
  input  logic [`PORTAL_TAG_W-1:0] wrTag,
  output logic wrStep,
  input  portalWordU wrData,
  input  logic enWrData,
  output logic rdyWrData,
  output logic [`PORTAL_RDDATA_W-1:0] rdData,
  input  logic enRdData,
  output logic rdyRdData,
  output logic [`PORTAL_TAG_W-1:0] wrDone,
  input  logic enWrDone,
  output logic rdyWrDone,
  input  logic [`PORTAL_DATA_W-1:0] ctrlData,
  input  logic [`PORTAL_DATA_W-1:0] heardValue,
  input  logic notEmpty,
  input  logic notFull,
  output logic sayPush,
  output portalWordU sayValue,
  output logic heardPop,
  output logic ctrlWrite,
  output logic [`PORTAL_ADDR_W-1:0] ctrlAddr,
  output portalWordU ctrlWord
);

  logic rdFire;
  logic wrFire;
  logic rdHeard;
  logic wrSay;
  logic [`PORTAL_DATA_W-1:0] rdValue;

  assign rdHeard = !rdSpace && rdAddr == `IND_HEARD;
  assign wrSay = !wrSpace && wrAddr == `METHOD_SAY;

  // Read beat fires when the output slot frees up and the indication has data
  assign rdFire = rdValid && (!rdyRdData || enRdData) && (!rdHeard || notEmpty) &&
                  !(rdSpace && ctrlWrite);    // Control write owns the decoder
  assign rdStep = rdFire;
  assign heardPop = rdFire && rdHeard;

  always_comb begin
    if (rdSpace) begin
      rdValue = ctrlData;
    end else if (rdAddr == `IND_HEARD) begin
      rdValue = heardValue;
    end else if (rdAddr == `IND_NOT_EMPTY) begin
      rdValue = {{(`PORTAL_DATA_W-1){1'b0}}, notEmpty};
    end else begin
      rdValue = '0;
    end
  end

  // Last beat waits for the done slot, method beat waits for queue room
  assign rdyWrData = wrValid && (!wrLast || !rdyWrDone) && (!wrSay || notFull);
  assign wrFire = enWrData && rdyWrData;
  assign wrStep = wrFire;

  assign sayPush = wrFire && wrSay;
  assign sayValue = wrData;
  assign ctrlWrite = wrFire && wrSpace;
  assign ctrlAddr = ctrlWrite ? wrAddr : rdAddr;
  assign ctrlWord = wrData;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      rdyRdData <= 1'b0;
      rdyWrDone <= 1'b0;
    end else begin
      if (rdFire) begin
        rdyRdData <= 1'b1;
      end else if (enRdData && rdyRdData) begin
        rdyRdData <= 1'b0;
      end
      if (wrFire && wrLast) begin
        rdyWrDone <= 1'b1;
      end else if (enWrDone && rdyWrDone) begin
        rdyWrDone <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (rdFire) begin
      rdData <= {rdValue, rdTag, rdLast};
    end
    if (wrFire && wrLast) begin
      wrDone <= wrTag;
    end
  end

  // A beat the host has not taken stays put
  assert property (@(posedge CLK) disable iff (!RST_N)
    (rdyRdData && !enRdData) |=> rdyRdData && $stable(rdData));

endmodule

//--- hdl/portalBurstCounter.sv
`timescale 1ns/1ns
`include "portal_params.svh"

module portalBurstCounter (
  input  logic CLK,
  input  logic RST_N,
  input  logic [`PORTAL_REQ_W-1:0] req,
  input  logic enReq,
  output logic rdyReq,
  input  logic beatStep,
  output logic beatValid,
  output logic beatLast,
  output logic beatSpace,
  output logic [`PORTAL_ADDR_W-1:0] beatAddr,
  output logic [`PORTAL_TAG_W-1:0] beatTag
);

  logic [`PORTAL_TAG_W-1:0] reqTag;
  logic [`PORTAL_LEN_W-1:0] reqLen;
  logic [`PORTAL_ADDR_W-1:0] reqAddr;
  logic [`PORTAL_LEN_W-1:0] remaining;

  assign reqTag = req[`PORTAL_REQ_W-1 -: `PORTAL_TAG_W];
  assign reqLen = req[`PORTAL_ADDR_W+1 +: `PORTAL_LEN_W];
  assign reqAddr = req[1 +: `PORTAL_ADDR_W];

  assign rdyReq = !beatValid;
  assign beatLast = remaining == `PORTAL_LEN_W'(1);

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      beatValid <= 1'b0;
    end else if (enReq && rdyReq) begin
      beatValid <= 1'b1;
    end else if (beatStep && beatLast) begin
      beatValid <= 1'b0;                     // Burst done
    end
  end

  always_ff @(posedge CLK) begin
    if (enReq && rdyReq) begin
      beatTag <= reqTag;
      beatSpace <= req[0];
      beatAddr <= reqAddr;
      remaining <= reqLen;
    end else if (beatStep) begin
      beatAddr <= beatAddr + `PORTAL_ADDR_W'(`PORTAL_BEAT_BYTES);  // Wraps mod 32
      remaining <= remaining - `PORTAL_LEN_W'(1);
    end
  end

  // Host must wait for the burst to drain before the next request
  assert property (@(posedge CLK) disable iff (!RST_N) beatValid |-> !enReq);
  assert property (@(posedge CLK) disable iff (!RST_N)
    enReq |-> reqLen != '0);

endmodule

//--- hdl/portalPkg.sv
`include "portal_params.svh"

package portalPkg;

  // One write beat, seen as an echo value or as the enable register word
  typedef union packed {
    logic [`PORTAL_DATA_W-1:0] echoValue;   // Data space view
    struct packed {
      logic [`PORTAL_DATA_W-2:0] reserved;
      logic intrEnable;
    } ctrlWord;                              // Control space view
  } portalWordU;

endpackage

//--- hdl/portal_params.svh
`ifndef PORTAL_PARAMS_SVH
`define PORTAL_PARAMS_SVH

`define PORTAL_DATA_W     32
`define PORTAL_ADDR_W     5
`define PORTAL_LEN_W      8
`define PORTAL_TAG_W      6
`define PORTAL_BEAT_BYTES 4
`define ECHO_DEPTH        8

// Request is {tag, length, address, space}
`define PORTAL_REQ_W    (`PORTAL_TAG_W + `PORTAL_LEN_W + `PORTAL_ADDR_W + 1)
// Read beat is {value, tag, last}
`define PORTAL_RDDATA_W (`PORTAL_DATA_W + `PORTAL_TAG_W + 1)

`define REG_INTR_STATUS  `PORTAL_ADDR_W'(0)
`define REG_INTR_ENABLE  `PORTAL_ADDR_W'(4)
`define REG_NUM_INTR     `PORTAL_ADDR_W'(8)
`define REG_INTR_CHANNEL `PORTAL_ADDR_W'(12)
`define REG_PORTAL_ID    `PORTAL_ADDR_W'(16)
`define REG_NUM_PORTALS  `PORTAL_ADDR_W'(20)
`define REG_RESERVED0    `PORTAL_ADDR_W'(24)
`define REG_RESERVED1    `PORTAL_ADDR_W'(28)

`define PORTAL_ID    `PORTAL_DATA_W'(5)
`define NUM_PORTALS  `PORTAL_DATA_W'(2)
`define NUM_INTR     `PORTAL_DATA_W'(1)
`define PORTAL_MAGIC `PORTAL_DATA_W'(32'h005A05A0)

`define METHOD_SAY    `PORTAL_ADDR_W'(0)
`define IND_HEARD     `PORTAL_ADDR_W'(0)
`define IND_NOT_EMPTY `PORTAL_ADDR_W'(4)

`endif
